// File: hdl/lsu_pkg.sv
package lsu_pkg;

  // bundle geometry
  localparam int N_SLOTS = 4;
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int BEN_W   = 4;
  localparam int TAG_W   = 6;

  // word address drops the byte offset
  localparam int WADDR_W = ADDR_W - 2;

  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } op_kind_e;

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } size_e;

  // one requested slot with right-justified store data
  typedef struct packed {
    op_kind_e            kind;
    size_e               size;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } mem_op_t;

  typedef struct packed {
    mem_op_t [N_SLOTS-1:0] op;
    logic [TAG_W-1:0]      tag;
  } bundle_t;

  // one decoded slot with data already in its byte lanes
  typedef struct packed {
    op_kind_e            kind;
    size_e               size;
    logic [WADDR_W-1:0]  waddr;
    logic [BEN_W-1:0]    ben;
    logic [DATA_W-1:0]   data;
    logic                misaligned;
  } lsq_entry_t;

  typedef struct packed {
    lsq_entry_t [N_SLOTS-1:0] slot;
    logic [TAG_W-1:0]         tag;
  } dec_bundle_t;

  // per-slot masks out of execute
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [N_SLOTS-1:0]  ops;
    logic [N_SLOTS-1:0]  conflict;
    logic [N_SLOTS-1:0]  excp;
  } exec_bundle_t;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [N_SLOTS-1:0]  ops;
    logic [N_SLOTS-1:0]  done;
    logic [N_SLOTS-1:0]  conflict;
    logic [N_SLOTS-1:0]  excp;
  } retire_t;

  // cache write port payload
  typedef struct packed {
    logic [WADDR_W-1:0]  waddr;
    logic [BEN_W-1:0]    ben;
    logic [DATA_W-1:0]   data;
  } store_req_t;

endpackage

// File: hdl/lsu_decode.sv
`timescale 1ns/1ps

module lsu_decode (
  input  logic                 clk,
  input  logic                 arst_n,
  input  lsu_pkg::bundle_t     in_bundle,
  input  logic                 accept,
  output lsu_pkg::dec_bundle_t dec,
  output logic                 dec_valid
);

  lsu_pkg::dec_bundle_t dec_nxt;

  // bytes touched by an access of this size at offset 0
  function automatic logic [lsu_pkg::BEN_W-1:0] size_mask(input lsu_pkg::size_e sz);
    case (sz)
      lsu_pkg::SZ_BYTE: size_mask = lsu_pkg::BEN_W'(1);
      lsu_pkg::SZ_HALF: size_mask = lsu_pkg::BEN_W'(3);
      default:          size_mask = '1;
    endcase
  endfunction

  // expand byte enables to a bit mask
  function automatic logic [lsu_pkg::DATA_W-1:0] lane_mask(
    input logic [lsu_pkg::BEN_W-1:0] ben
  );
    logic [lsu_pkg::DATA_W-1:0] m;
    for (int b = 0; b < lsu_pkg::BEN_W; b++) begin
      m[8*b +: 8] = {8{ben[b]}};
    end
    return m;
  endfunction

  function automatic logic is_misaligned(input lsu_pkg::size_e sz, input logic [1:0] lo);
    case (sz)
      lsu_pkg::SZ_BYTE: is_misaligned = 1'b0;
      lsu_pkg::SZ_HALF: is_misaligned = lo[0];
      default:          is_misaligned = (lo != 2'b00);
    endcase
  endfunction

  always_comb begin
    dec_nxt.tag = in_bundle.tag;
    for (int s = 0; s < lsu_pkg::N_SLOTS; s++) begin
      dec_nxt.slot[s].kind  = in_bundle.op[s].kind;
      dec_nxt.slot[s].size  = in_bundle.op[s].size;
      dec_nxt.slot[s].waddr = in_bundle.op[s].addr[lsu_pkg::ADDR_W-1:2];
      dec_nxt.slot[s].misaligned = (in_bundle.op[s].kind != lsu_pkg::OP_NONE) &&
          is_misaligned(in_bundle.op[s].size, in_bundle.op[s].addr[1:0]);
      dec_nxt.slot[s].ben  = '0;
      dec_nxt.slot[s].data = '0;
      if (in_bundle.op[s].kind != lsu_pkg::OP_NONE && !dec_nxt.slot[s].misaligned) begin
        dec_nxt.slot[s].ben = size_mask(in_bundle.op[s].size) << in_bundle.op[s].addr[1:0];
      end
      // store data trimmed to size then moved into its lanes
      if (in_bundle.op[s].kind == lsu_pkg::OP_STORE && !dec_nxt.slot[s].misaligned) begin
        dec_nxt.slot[s].data =
            (in_bundle.op[s].data & lane_mask(size_mask(in_bundle.op[s].size)))
            << {in_bundle.op[s].addr[1:0], 3'b000};
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec <= dec_nxt;
    end
  end

endmodule

// File: hdl/lsu_store_queue.sv
`timescale 1ns/1ps

module lsu_store_queue #(
  parameter int STQ_DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  lsu_pkg::dec_bundle_t  dec,
  input  logic                  dec_valid,
  input  logic                  st_ready,
  output logic                  in_stall,
  output lsu_pkg::exec_bundle_t exe,
  output logic                  exe_valid,
  output lsu_pkg::store_req_t   st_req,
  output logic                  st_valid
);

  localparam int PTR_W = $clog2(STQ_DEPTH);
  localparam int CNT_W = $clog2(STQ_DEPTH + lsu_pkg::N_SLOTS + 1);

  lsu_pkg::store_req_t mem [STQ_DEPTH];

  logic [PTR_W-1:0]           head;
  logic [PTR_W-1:0]           tail;
  logic [CNT_W-1:0]           count;
  logic [CNT_W-1:0]           n_push;
  logic                       pop;
  logic [STQ_DEPTH-1:0]       ent_vld;
  logic [lsu_pkg::N_SLOTS-1:0] ops;
  logic [lsu_pkg::N_SLOTS-1:0] excp;
  logic [lsu_pkg::N_SLOTS-1:0] is_load;
  logic [lsu_pkg::N_SLOTS-1:0] is_store;
  logic [lsu_pkg::N_SLOTS-1:0] push_en;
  logic [lsu_pkg::N_SLOTS-1:0] ld_confl;
  logic [PTR_W-1:0]           wr_idx [lsu_pkg::N_SLOTS];

  // pointer advance with wrap at the depth
  function automatic logic [PTR_W-1:0] ptr_add(
    input logic [PTR_W-1:0] p,
    input logic [CNT_W-1:0] n
  );
    int sum;
    sum = int'(p) + int'(n);
    if (sum >= STQ_DEPTH) begin
      sum = sum - STQ_DEPTH;
    end
    return PTR_W'(sum);
  endfunction

  function automatic logic overlaps(
    input logic [lsu_pkg::WADDR_W-1:0] wa,
    input logic [lsu_pkg::BEN_W-1:0]   ba,
    input logic [lsu_pkg::WADDR_W-1:0] wb,
    input logic [lsu_pkg::BEN_W-1:0]   bb
  );
    return (wa == wb) && ((ba & bb) != '0);
  endfunction

  // slot classification
  always_comb begin
    for (int s = 0; s < lsu_pkg::N_SLOTS; s++) begin
      ops[s]      = dec.slot[s].kind != lsu_pkg::OP_NONE;
      excp[s]     = dec.slot[s].misaligned;
      is_load[s]  = dec.slot[s].kind == lsu_pkg::OP_LOAD && !dec.slot[s].misaligned;
      is_store[s] = dec.slot[s].kind == lsu_pkg::OP_STORE && !dec.slot[s].misaligned;
      push_en[s]  = is_store[s] && dec_valid;
    end
  end

  // stores packed into the FIFO in slot order
  always_comb begin
    n_push = '0;
    for (int s = 0; s < lsu_pkg::N_SLOTS; s++) begin
      wr_idx[s] = ptr_add(tail, n_push);
      if (push_en[s]) begin
        n_push = n_push + 1'b1;
      end
    end
  end

  // live entries lie between head and head + count
  always_comb begin
    for (int i = 0; i < STQ_DEPTH; i++) begin
      ent_vld[i] = (i >= int'(head)) ? (i - int'(head) < int'(count))
                                     : (i + STQ_DEPTH - int'(head) < int'(count));
    end
  end

  // loads vs queued stores and older stores of the same bundle
  always_comb begin
    ld_confl = '0;
    for (int s = 0; s < lsu_pkg::N_SLOTS; s++) begin
      if (is_load[s]) begin
        for (int i = 0; i < STQ_DEPTH; i++) begin
          if (ent_vld[i] &&
              overlaps(mem[i].waddr, mem[i].ben, dec.slot[s].waddr, dec.slot[s].ben)) begin
            ld_confl[s] = 1'b1;
          end
        end
        for (int j = 0; j < s; j++) begin
          if (is_store[j] && overlaps(dec.slot[j].waddr, dec.slot[j].ben,
                                      dec.slot[s].waddr, dec.slot[s].ben)) begin
            ld_confl[s] = 1'b1;
          end
        end
      end
    end
  end

  assign st_req   = mem[head];
  assign st_valid = count != '0;
  assign pop      = st_valid && st_ready;
  assign in_stall = (count + n_push) > CNT_W'(STQ_DEPTH - lsu_pkg::N_SLOTS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      exe_valid <= 1'b0;
    end else begin
      if (pop) begin
        head <= ptr_add(head, CNT_W'(1));
      end
      tail      <= ptr_add(tail, n_push);
      count     <= count + n_push - CNT_W'(pop);
      exe_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    for (int s = 0; s < lsu_pkg::N_SLOTS; s++) begin
      if (push_en[s]) begin
        mem[wr_idx[s]] <= '{waddr: dec.slot[s].waddr,
                            ben:   dec.slot[s].ben,
                            data:  dec.slot[s].data};
      end
    end
    exe.tag      <= dec.tag;
    exe.ops      <= ops;
    exe.conflict <= ld_confl;
    exe.excp     <= excp;
  end

endmodule

// File: hdl/lsu_retire.sv
`timescale 1ns/1ps

module lsu_retire (
  input  logic                  clk,
  input  logic                  arst_n,
  input  lsu_pkg::exec_bundle_t exe,
  input  logic                  exe_valid,
  output lsu_pkg::retire_t      ret,
  output logic                  ret_valid
);

  logic [lsu_pkg::N_SLOTS-1:0] live;
  logic [lsu_pkg::N_SLOTS-1:0] conflict_nxt;
  logic [lsu_pkg::N_SLOTS-1:0] done_nxt;
  logic [lsu_pkg::N_SLOTS-1:0] excp_nxt;

  // present slots that did not fault
  assign live = exe.ops & ~exe.excp;

  // only aligned loads can be flagged by execute
  assign conflict_nxt = exe.conflict & live;

  assign done_nxt = live & ~conflict_nxt;

  // empty slots never report a fault
  assign excp_nxt = exe.excp & exe.ops;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ret_valid <= 1'b0;
    end else begin
      ret_valid <= exe_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_valid) begin
      ret.tag      <= exe.tag;
      ret.ops      <= exe.ops;
      ret.done     <= done_nxt;
      ret.conflict <= conflict_nxt;
      ret.excp     <= excp_nxt;
    end
  end

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int STQ_DEPTH = 16
) (
  input  logic                clk,
  input  logic                arst_n,
  input  lsu_pkg::bundle_t    in_bundle,
  input  logic                in_valid,
  input  logic                st_ready,
  output logic                in_stall,
  output lsu_pkg::retire_t    ret,
  output logic                ret_valid,
  output lsu_pkg::store_req_t st_req,
  output logic                st_valid
);

  logic                  accept;
  lsu_pkg::dec_bundle_t  dec;
  logic                  dec_valid;
  lsu_pkg::exec_bundle_t exe;
  logic                  exe_valid;

  assign accept = in_valid && !in_stall;

  lsu_decode i_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_bundle (in_bundle),
    .accept    (accept),
    .dec       (dec),
    .dec_valid (dec_valid)
  );

  lsu_store_queue #(
    .STQ_DEPTH (STQ_DEPTH)
  ) i_store_queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec       (dec),
    .dec_valid (dec_valid),
    .st_ready  (st_ready),
    .in_stall  (in_stall),
    .exe       (exe),
    .exe_valid (exe_valid),
    .st_req    (st_req),
    .st_valid  (st_valid)
  );

  lsu_retire i_retire (
    .clk       (clk),
    .arst_n    (arst_n),
    .exe       (exe),
    .exe_valid (exe_valid),
    .ret       (ret),
    .ret_valid (ret_valid)
  );

endmodule

// File: test/lsu_clock_gen.sv
`timescale 1ns/1ps

module lsu_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// File: test/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  localparam int    STQ_DEPTH = 16;
  localparam string STIM_FILE = "test/lsu_stimulus.txt";

  logic                clk;
  logic                arst_n;
  lsu_pkg::bundle_t    in_bundle;
  logic                in_valid;
  logic                st_ready;
  logic                in_stall;
  lsu_pkg::retire_t    ret;
  logic                ret_valid;
  lsu_pkg::store_req_t st_req;
  logic                st_valid;

  lsu_pkg::retire_t    exp_ret[$];
  lsu_pkg::store_req_t exp_st[$];

  int checks = 0;
  int errors = 0;
  int cycles = 0;
  int limit  = 0;

  lsu_clock_gen #(
    .PERIOD_NS  (40),
    .RST_CYCLES (2)
  ) i_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  lsu_top #(
    .STQ_DEPTH (STQ_DEPTH)
  ) i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_bundle (in_bundle),
    .in_valid  (in_valid),
    .st_ready  (st_ready),
    .in_stall  (in_stall),
    .ret       (ret),
    .ret_valid (ret_valid),
    .st_req    (st_req),
    .st_valid  (st_valid)
  );

  // run limit in clock cycles
  initial begin
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Some tests failed");
    $finish;
  end

  // retire records in acceptance order
  always @(negedge clk) begin
    if (arst_n && ret_valid) begin
      checks++;
      if (exp_ret.size() == 0) begin
        errors++;
        $display("unexpected retire record with tag %0d at %0t", ret.tag, $time);
      end else begin
        assert (ret === exp_ret[0]) else begin
          errors++;
          $display("FAILED %0t: retire tag %0d ops %h done %h confl %h excp %h", $time,
                   ret.tag, ret.ops, ret.done, ret.conflict, ret.excp);
          $display("  expected tag %0d ops %h done %h confl %h excp %h", exp_ret[0].tag,
                   exp_ret[0].ops, exp_ret[0].done, exp_ret[0].conflict, exp_ret[0].excp);
        end
        void'(exp_ret.pop_front());
      end
    end
  end

  // a transfer takes place on the next rising edge
  always @(negedge clk) begin
    if (arst_n && st_valid && st_ready) begin
      checks++;
      if (exp_st.size() == 0) begin
        errors++;
        $display("unexpected store transfer to word %h at %0t", st_req.waddr, $time);
      end else begin
        assert (st_req === exp_st[0]) else begin
          errors++;
          $display("FAILED %0t: store word %h ben %h data %h, expected %h %h %h", $time,
                   st_req.waddr, st_req.ben, st_req.data,
                   exp_st[0].waddr, exp_st[0].ben, exp_st[0].data);
        end
        void'(exp_st.pop_front());
      end
    end
  end

  task automatic send_bundle(input lsu_pkg::bundle_t b, input lsu_pkg::retire_t r);
    int gap;
    gap = $urandom % 3;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    in_bundle <= b;
    in_valid  <= 1'b1;
    @(negedge clk);
    while (in_stall) @(negedge clk);
    @(posedge clk);
    in_valid <= 1'b0;
    exp_ret.push_back(r);
  endtask

  task automatic wait_idle(input bit with_stores);
    while (exp_ret.size() != 0) @(negedge clk);
    if (with_stores && st_ready) begin
      while (exp_st.size() != 0) @(negedge clk);
    end
  endtask

  task automatic check_stall(input logic v);
    wait_idle(1'b0);
    @(negedge clk);
    checks++;
    assert (in_stall === v) else begin
      errors++;
      $display("FAILED %0t: in_stall is %b, expected %b", $time, in_stall, v);
    end
  endtask

  task automatic close_test(input string name, input int err_start);
    wait_idle(1'b1);
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  initial begin
    int                          fd;
    int                          rc;
    int                          n_lines;
    int                          test_err;
    bit                          in_test;
    string                       line;
    string                       test_name;
    logic [31:0]                 f [20];
    logic [lsu_pkg::TAG_W-1:0]   tag_seq;
    lsu_pkg::bundle_t            b;
    lsu_pkg::retire_t            r;
    lsu_pkg::store_req_t         s;

    in_bundle = '0;
    in_valid  = 1'b0;
    st_ready  = 1'b0;
    void'($urandom(45422));
    tag_seq  = '0;
    in_test  = 1'b0;
    test_err = 0;
    n_lines  = 0;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open stimulus file %s", STIM_FILE);
    end else begin
      while ($fgets(line, fd) != 0) n_lines++;
      $fclose(fd);
      fd = $fopen(STIM_FILE, "r");
    end
    limit = 3 + 8 * n_lines + 4 * STQ_DEPTH;

    wait (arst_n === 1'b1);
    @(posedge clk);

    while (fd != 0 && $fgets(line, fd) != 0) begin
      if (line.len() == 0) begin
        rc = 0;
      end else if (line.getc(0) == "N") begin
        if (in_test) close_test(test_name, test_err);
        rc = $sscanf(line, "N %s", test_name);
        test_err = errors;
        in_test  = 1'b1;
      end else if (line.getc(0) == "R") begin
        rc = $sscanf(line, "R %h", f[0]);
        @(posedge clk);
        st_ready <= f[0][0];
      end else if (line.getc(0) == "S") begin
        rc = $sscanf(line, "S %h", f[0]);
        check_stall(f[0][0]);
      end else if (line.getc(0) == "T") begin
        rc = $sscanf(line, "T %h %h %h", f[0], f[1], f[2]);
        s.waddr = f[0][lsu_pkg::WADDR_W-1:0];
        s.ben   = f[1][lsu_pkg::BEN_W-1:0];
        s.data  = f[2];
        exp_st.push_back(s);
      end else if (line.getc(0) == "B") begin
        rc = $sscanf(line, "B %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                     f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
        if (rc != 20) begin
          errors++;
          $display("malformed bundle line in stimulus file: %s", line);
        end
        b.tag = tag_seq;
        for (int i = 0; i < lsu_pkg::N_SLOTS; i++) begin
          b.op[i].kind = lsu_pkg::op_kind_e'(f[4*i][1:0]);
          b.op[i].size = lsu_pkg::size_e'(f[4*i+1][1:0]);
          b.op[i].addr = f[4*i+2];
          b.op[i].data = f[4*i+3];
        end
        r.tag      = tag_seq;
        r.ops      = f[16][3:0];
        r.done     = f[17][3:0];
        r.conflict = f[18][3:0];
        r.excp     = f[19][3:0];
        send_bundle(b, r);
        tag_seq++;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (in_test) close_test(test_name, test_err);

    // every expected store left exactly once
    repeat (2) @(negedge clk);
    checks++;
    assert (st_valid === 1'b0 && exp_st.size() == 0) else begin
      errors++;
      $display("store port still busy at the end with %0d expected transfers left",
               exp_st.size());
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: test/lsu_stimulus.txt
# B: 4 slots of kind size addr data (kind 0 none 1 load 2 store, size 0 byte 1 half 2 word)
#    then ops done conflict excp masks; R ready; S stall; T waddr ben data; N test name
N align
R 1
B 2 0 100 ab 2 0 101 cd 2 0 102 12 2 0 103 1234 f f 0 0
T 40 1 000000ab
T 40 2 0000cd00
T 40 4 00120000
T 40 8 34000000
B 2 1 104 5678 2 1 106 ffff9abc 2 2 108 deadbeef 0 0 0 0 7 7 0 0
T 41 3 00005678
T 41 c 9abc0000
T 42 f deadbeef
B 2 1 111 aaaa 2 2 112 bbbbbbbb 1 2 115 0 2 0 113 77 f 8 0 7
T 44 8 77000000
N queue_conflict
R 0
B 2 2 200 11223344 2 0 305 55 0 0 0 0 0 0 0 0 3 3 0 0
T 80 f 11223344
T c1 2 00005500
B 1 0 203 0 1 1 304 0 1 0 306 0 1 2 400 0 f c 3 0
N bundle_conflict
B 1 2 500 0 2 1 502 beef 1 0 503 0 1 0 500 0 f b 4 0
T 140 c beef0000
B 2 0 601 9a 1 1 600 0 0 0 0 0 1 1 601 0 b 1 2 8
T 180 2 00009a00
N retire_order
B 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
B 0 0 0 0 1 2 700 0 0 0 0 0 1 0 704 0 a a 0 0
N back_pressure
B 2 2 800 11111111 2 2 804 22222222 2 2 808 33333333 2 2 80c 44444444 f f 0 0
T 200 f 11111111
T 201 f 22222222
T 202 f 33333333
T 203 f 44444444
B 2 2 810 55555555 2 2 814 66666666 2 2 818 77777777 2 2 81c 88888888 f f 0 0
T 204 f 55555555
T 205 f 66666666
T 206 f 77777777
T 207 f 88888888
B 2 0 820 99 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
T 208 1 00000099
S 1
R 1
B 2 1 822 1234 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0
T 208 c 12340000

// File: sim.f
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_store_queue.sv
hdl/lsu_retire.sv
hdl/lsu_top.sv
test/lsu_clock_gen.sv
test/lsu_tb.sv
